/* vlog.f */
+incdir+.
icache_pkg.sv
icache_way.sv
icache_lru.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

/* Makefile */
TOP = tb_icache

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* tb_icache.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module tb_icache;

        localparam logic [31:0] SEED        = 32'h0444_2317;
        localparam logic [31:0] MEM_PATTERN = 32'hC0DE_0000;
        localparam int ACCESS_BUDGET  = 300;
        localparam int ACCESS_CYCLES  = 60;
        localparam int TIMEOUT_CYCLES = ACCESS_BUDGET * ACCESS_CYCLES + 2000;

        logic                       clk       = 1'b0;
        logic                       resetn    = 1'b0;
        logic [31:0]                s_araddr  = '0;
        logic                       s_arvalid = 1'b0;
        logic                       s_arready;
        logic [31:0]                s_rdata;
        logic                       s_rvalid;
        logic                       s_rready  = 1'b0;
        logic [31:0]                m_araddr;
        logic [`ICACHE_ARLEN_W-1:0] m_arlen;
        logic                       m_arvalid;
        logic                       m_arready = 1'b0;
        logic [31:0]                m_rdata   = '0;
        logic                       m_rvalid  = 1'b0;
        logic                       m_rlast   = 1'b0;
        logic                       m_rready;

        logic [31:0]                rnd_q     = SEED;
        logic [31:0]                req_addr  = '0;
        logic                       pending   = 1'b0;
        logic                       exp_known = 1'b0;
        logic                       exp_hit   = 1'b0;
        logic                       accepted;
        logic [31:0]                exp_data;
        logic [`ICACHE_ARLEN_W-1:0] exp_arlen;
        int                         cycle_count = 0;
        int                         errors      = 0;
        int                         n_tests     = 0;
        int                         n_access    = 0;
        int                         test_start  = 0;

        icache_top UUT (
                .clk       (clk),
                .resetn    (resetn),
                .s_araddr  (s_araddr),
                .s_arvalid (s_arvalid),
                .s_arready (s_arready),
                .s_rdata   (s_rdata),
                .s_rvalid  (s_rvalid),
                .s_rready  (s_rready),
                .m_araddr  (m_araddr),
                .m_arlen   (m_arlen),
                .m_arvalid (m_arvalid),
                .m_arready (m_arready),
                .m_rdata   (m_rdata),
                .m_rvalid  (m_rvalid),
                .m_rlast   (m_rlast),
                .m_rready  (m_rready)
        );

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic logic [31:0] word_addr(input logic [`ICACHE_TAG_W-1:0] tag,
                                                  input logic [`ICACHE_INDEX_W-1:0] index,
                                                  input logic [`ICACHE_WORD_W-1:0] word);
                return {tag, index, word, 2'b00};
        endfunction

        initial
        begin
                forever #2 clk = ~clk;
        end

        always @(posedge clk)
                cycle_count <= cycle_count + 1;

        // Random stalls on both ready inputs
        always @(posedge clk)
        begin
                rnd_q     <= xorshift32(rnd_q);
                s_rready  <= (rnd_q[3:2] != 2'b00);
                m_arready <= (rnd_q[5:4] != 2'b00);
        end

        //////////////////////////////////////////////////
        // Memory model
        //////////////////////////////////////////////////
        logic                       mem_busy = 1'b0;
        logic [31:0]                mem_addr = '0;
        logic [`ICACHE_ARLEN_W-1:0] mem_beat = '0;
        logic [`ICACHE_ARLEN_W-1:0] mem_len  = '0;
        logic [3:0]                 mem_wait = '0;

        always @(posedge clk)
        begin
                if (!resetn)
                begin
                        mem_busy <= 1'b0;
                        m_rvalid <= 1'b0;
                        m_rlast  <= 1'b0;
                end
                else if (!mem_busy)
                begin
                        if (m_arvalid && m_arready)
                        begin
                                mem_busy <= 1'b1;
                                mem_addr <= {m_araddr[31:2], 2'b00};
                                mem_len  <= m_arlen;
                                mem_beat <= '0;
                                mem_wait <= rnd_q[11:8];
                        end
                end
                else if (!m_rvalid)
                begin
                        if (mem_wait == 4'd0)
                        begin
                                m_rvalid <= 1'b1;
                                m_rdata  <= mem_addr ^ MEM_PATTERN;
                                m_rlast  <= (mem_beat == mem_len);
                        end
                        else
                                mem_wait <= mem_wait - 4'd1;
                end
                else if (m_rready)
                begin
                        if (m_rlast)
                        begin
                                m_rvalid <= 1'b0;
                                m_rlast  <= 1'b0;
                                mem_busy <= 1'b0;
                        end
                        else
                        begin
                                m_rdata  <= (mem_addr + 32'd4) ^ MEM_PATTERN;
                                m_rlast  <= (mem_beat + 1'b1 == mem_len);
                                mem_addr <= mem_addr + 32'd4;
                                mem_beat <= mem_beat + 1'b1;
                        end
                end
        end

        //////////////////////////////////////////////////
        // Request tracking and checks
        //////////////////////////////////////////////////
        assign accepted  = s_arvalid && s_arready;
        assign exp_data  = {req_addr[31:2], 2'b00} ^ MEM_PATTERN;
        assign exp_arlen = `ICACHE_ARLEN_W'(3 - req_addr[3:2]);

        always @(posedge clk)
        begin
                if (accepted)
                        req_addr <= s_araddr;
                if (!resetn)
                        pending <= 1'b0;
                else if (accepted)
                        pending <= 1'b1;
                else if (s_rvalid && s_rready)
                        pending <= 1'b0;
        end

        assert property (@(posedge clk)
                $rose(resetn) |-> s_arready && !s_rvalid && !m_arvalid && !m_rready)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: port values wrong after reset", $time);
        end

        assert property (@(posedge clk) disable iff (!resetn)
                m_arvalid |-> m_araddr == req_addr && m_arlen == exp_arlen)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: burst %h len %0d, expected %h len %0d", $time,
                         $sampled(m_araddr), $sampled(m_arlen), req_addr, exp_arlen);
        end

        assert property (@(posedge clk) disable iff (!resetn)
                s_rvalid && s_rready |-> s_rdata == exp_data)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: s_rdata %h, expected %h", $time,
                         $sampled(s_rdata), exp_data);
        end

        assert property (@(posedge clk) disable iff (!resetn) $past(accepted) |-> !s_rvalid)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: s_rvalid one cycle after the request", $time);
        end

        // Hit answers two cycles after acceptance and a miss does not
        assert property (@(posedge clk) disable iff (!resetn)
                exp_known && $past(accepted, 2) |-> s_rvalid == exp_hit)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: s_rvalid %b two cycles after %h, expected %b",
                         $time, $sampled(s_rvalid), req_addr, exp_hit);
        end

        assert property (@(posedge clk) disable iff (!resetn)
                exp_known && !exp_hit && $past(accepted, 3) |-> m_arvalid)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: no burst request for the miss at %h",
                         $time, req_addr);
        end

        assert property (@(posedge clk) disable iff (!resetn)
                m_arvalid |-> !(exp_known && exp_hit))
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: burst request for the hit at %h", $time, req_addr);
        end

        assert property (@(posedge clk) disable iff (!resetn)
                s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: response changed while stalled", $time);
        end

        assert property (@(posedge clk) disable iff (!resetn)
                m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen))
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: burst request changed while stalled", $time);
        end

        assert property (@(posedge clk) disable iff (!resetn) m_rvalid |-> m_rready)
        else
        begin
                errors = errors + 1;
                $display("FAILED at %0t: beat offered while m_rready is low", $time);
        end

        assert property (@(posedge clk) disable iff (!resetn) accepted |-> !pending)
        else
        begin
                errors = errors + 1;
                $display("A new request was taken before the previous one was answered");
        end

        //////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////
        task automatic read_word(input logic [31:0] addr, input logic known,
                                 input logic hit);
                @(posedge clk);
                exp_known <= known;
                exp_hit   <= hit;
                s_araddr  <= addr;
                s_arvalid <= 1'b1;
                @(negedge clk);
                while (!s_arready)
                        @(negedge clk);
                @(posedge clk);
                s_arvalid <= 1'b0;
                // Idle again once the word is taken and the burst is over
                @(negedge clk);
                while (!s_arready)
                        @(negedge clk);
                n_access++;
        endtask

        task automatic close_test(input string name);
                n_tests++;
                $display("test %0d %s done: %0d accesses, %0d errors so far",
                         n_tests, name, n_access - test_start, errors);
                test_start = n_access;
        endtask

        initial
        begin
                logic [31:0]               stim_rng;
                logic [`ICACHE_TAG_W-1:0]  fill_tag [8];
                logic [`ICACHE_WORD_W-1:0] fill_word [8];
                logic [`ICACHE_TAG_W-1:0]  tag;

                stim_rng = SEED;
                repeat (10) @(posedge clk);
                resetn <= 1'b1;
                repeat (2) @(posedge clk);
                close_test("reset values");

                for (int i = 0; i < 8; i++)
                begin
                        stim_rng     = xorshift32(stim_rng);
                        fill_tag[i]  = stim_rng[31:9];
                        fill_word[i] = stim_rng[1:0];
                        read_word(word_addr(fill_tag[i], 5'(i), fill_word[i]), 1'b1, 1'b0);
                end
                close_test("miss refill");

                // Any word from the critical word upward was filled
                for (int i = 0; i < 8; i++)
                begin
                        stim_rng = xorshift32(stim_rng);
                        read_word(word_addr(fill_tag[i], 5'(i), fill_word[i] | stim_rng[1:0]),
                                  1'b1, 1'b1);
                end
                close_test("hit");

                tag = 23'h2A_5A5A;
                read_word(word_addr(tag, 5'd24, 2'd2), 1'b1, 1'b0);
                read_word(word_addr(tag, 5'd24, 2'd0), 1'b1, 1'b0);
                read_word(word_addr(tag, 5'd24, 2'd3), 1'b1, 1'b1);
                close_test("partial line");

                // A B A C A B in one set
                read_word(word_addr(23'h1A0, 5'd20, 2'd0), 1'b1, 1'b0);
                read_word(word_addr(23'h1B0, 5'd20, 2'd0), 1'b1, 1'b0);
                read_word(word_addr(23'h1A0, 5'd20, 2'd0), 1'b1, 1'b1);
                read_word(word_addr(23'h1C0, 5'd20, 2'd0), 1'b1, 1'b0);
                read_word(word_addr(23'h1A0, 5'd20, 2'd0), 1'b1, 1'b1);
                read_word(word_addr(23'h1B0, 5'd20, 2'd0), 1'b1, 1'b0);
                close_test("replacement");

                for (int i = 0; i < 200; i++)
                begin
                        stim_rng = xorshift32(stim_rng);
                        read_word(word_addr(23'h40 + 23'(stim_rng[9:8]),
                                            5'd28 + 5'(stim_rng[5:4]), stim_rng[1:0]),
                                  1'b0, 1'b0);
                end
                close_test("back-pressure");

                repeat (5) @(posedge clk);
                $display("%0d tests, %0d accesses, %0d errors", n_tests, n_access, errors);
                if (errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

        initial
        begin
                wait (cycle_count == TIMEOUT_CYCLES);
                $display("Timeout after %0d cycles, the cache stopped answering requests",
                         cycle_count);
                $display("TEST FAILED");
                $finish;
        end

endmodule

/* icache_top.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top import icache_pkg::*;
(
        input  logic                       clk,
        input  logic                       resetn,

        input  logic [31:0]                s_araddr,
        input  logic                       s_arvalid,
        output logic                       s_arready,
        output logic [31:0]                s_rdata,
        output logic                       s_rvalid,
        input  logic                       s_rready,

        output logic [31:0]                m_araddr,
        output logic [`ICACHE_ARLEN_W-1:0] m_arlen,
        output logic                       m_arvalid,
        input  logic                       m_arready,
        input  logic [31:0]                m_rdata,
        input  logic                       m_rvalid,
        input  logic                       m_rlast,
        output logic                       m_rready
);

        way_lookup_t                way0_res;
        way_lookup_t                way1_res;
        refill_wr_t                 refill;
        logic                       lookup;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_WORD_W-1:0]  word;
        logic [`ICACHE_TAG_W-1:0]   req_tag;
        logic                       hit_clear0;
        logic                       hit_clear1;
        logic                       used;
        logic                       used_way;
        logic                       victim;

        //////////////////////////////////////////////////
        // Ways with one write strobe each
        //////////////////////////////////////////////////
        icache_way u_way0 (
                .clk       (clk),
                .resetn    (resetn),
                .lookup    (lookup),
                .index     (index),
                .word      (word),
                .refill    (refill),
                .wr_en     (refill.way_sel[0]),
                .hit_clear (hit_clear0),
                .req_tag   (req_tag),
                .result    (way0_res)
        );

        icache_way u_way1 (
                .clk       (clk),
                .resetn    (resetn),
                .lookup    (lookup),
                .index     (index),
                .word      (word),
                .refill    (refill),
                .wr_en     (refill.way_sel[1]),
                .hit_clear (hit_clear1),
                .req_tag   (req_tag),
                .result    (way1_res)
        );

        icache_lru u_lru (
                .clk      (clk),
                .resetn   (resetn),
                .lookup   (lookup),
                .index    (index),
                .used     (used),
                .used_way (used_way),
                .way0     (way0_res),
                .way1     (way1_res),
                .victim   (victim)
        );

        icache_ctrl u_ctrl (
                .clk        (clk),
                .resetn     (resetn),
                .s_araddr   (s_araddr),
                .s_arvalid  (s_arvalid),
                .s_arready  (s_arready),
                .s_rdata    (s_rdata),
                .s_rvalid   (s_rvalid),
                .s_rready   (s_rready),
                .m_araddr   (m_araddr),
                .m_arlen    (m_arlen),
                .m_arvalid  (m_arvalid),
                .m_arready  (m_arready),
                .m_rdata    (m_rdata),
                .m_rvalid   (m_rvalid),
                .m_rlast    (m_rlast),
                .m_rready   (m_rready),
                .way0       (way0_res),
                .way1       (way1_res),
                .victim     (victim),
                .lookup     (lookup),
                .index      (index),
                .word       (word),
                .req_tag    (req_tag),
                .hit_clear0 (hit_clear0),
                .hit_clear1 (hit_clear1),
                .used       (used),
                .used_way   (used_way),
                .refill     (refill)
        );

endmodule

/* icache_ctrl.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_ctrl import icache_pkg::*;
(
        input  logic                       clk,
        input  logic                       resetn,
        input  logic [31:0]                s_araddr,
        input  logic                       s_arvalid,
        output logic                       s_arready,
        output logic [31:0]                s_rdata,
        output logic                       s_rvalid,
        input  logic                       s_rready,
        output logic [31:0]                m_araddr,
        output logic [`ICACHE_ARLEN_W-1:0] m_arlen,
        output logic                       m_arvalid,
        input  logic                       m_arready,
        input  logic [31:0]                m_rdata,
        input  logic                       m_rvalid,
        input  logic                       m_rlast,
        output logic                       m_rready,
        input  way_lookup_t                way0,
        input  way_lookup_t                way1,
        input  logic                       victim,
        output logic                       lookup,
        output logic [`ICACHE_INDEX_W-1:0] index,
        output logic [`ICACHE_WORD_W-1:0]  word,
        output logic [`ICACHE_TAG_W-1:0]   req_tag,
        output logic                       hit_clear0,
        output logic                       hit_clear1,
        output logic                       used,
        output logic                       used_way,
        output refill_wr_t                 refill
);

        typedef enum logic [5:0] {
                S_IDLE = 6'b000001,
                S_TAG  = 6'b000010,
                S_CMP  = 6'b000100,
                S_MREQ = 6'b001000,
                S_CRIT = 6'b010000,
                S_REST = 6'b100000
        } state_t;

        state_t                    state;
        state_t                    state_nx;
        icache_addr_u              req_q;
        logic                      victim_q;
        logic [`ICACHE_WORD_W-1:0] beat_q;
        logic [31:0]               crit_q;
        logic                      crit_vld_q;
        logic                      last_seen_q;
        logic                      hit0;
        logic                      hit1;
        logic                      any_hit;
        logic                      beat;
        logic                      burst_done;
        logic                      crit_done;

        assign hit0       = way0.hit && way0.valid;
        assign hit1       = way1.hit && way1.valid;
        assign any_hit    = hit0 || hit1;
        assign beat       = m_rvalid && m_rready;
        assign burst_done = last_seen_q || (beat && m_rlast);
        assign crit_done  = !crit_vld_q || s_rready;

        //////////////////////////////////////////////////
        // Request FSM
        //////////////////////////////////////////////////
        always_comb
        begin
                state_nx = state;
                case (state)
                S_IDLE:
                        if (s_arvalid)
                                state_nx = S_TAG;
                S_TAG:
                        state_nx = S_CMP;
                S_CMP:
                        if (!any_hit)
                                state_nx = S_MREQ;
                        else if (s_rready)
                                state_nx = S_IDLE;
                S_MREQ:
                        if (m_arready)
                                state_nx = S_CRIT;
                S_CRIT:
                        if (m_rvalid)
                                state_nx = S_REST;
                S_REST:
                        // Last beat and critical word taken in either order
                        if (burst_done && crit_done)
                                state_nx = S_IDLE;
                default:
                        state_nx = S_IDLE;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (!resetn)
                        state <= S_IDLE;
                else
                        state <= state_nx;
        end

        always_ff @(posedge clk)
        begin
                if (!resetn)
                begin
                        victim_q    <= 1'b0;
                        beat_q      <= '0;
                        crit_vld_q  <= 1'b0;
                        last_seen_q <= 1'b0;
                end
                else
                begin
                        if (state == S_CMP && !any_hit)
                                victim_q <= victim;
                        // Burst starts at the requested word
                        if (state == S_MREQ && m_arready)
                        begin
                                beat_q      <= req_q.f.word;
                                last_seen_q <= 1'b0;
                        end
                        else if (beat)
                        begin
                                beat_q <= beat_q + 1'b1;
                                if (m_rlast)
                                        last_seen_q <= 1'b1;
                        end
                        if (state == S_CRIT && m_rvalid)
                                crit_vld_q <= 1'b1;
                        else if (s_rready)
                                crit_vld_q <= 1'b0;
                end
        end

        always_ff @(posedge clk)
        begin
                if (s_arvalid && s_arready)
                        req_q.raw <= s_araddr;
                if (state == S_CRIT && m_rvalid)
                        crit_q <= m_rdata;
        end

        //////////////////////////////////////////////////
        // Outputs
        //////////////////////////////////////////////////
        assign s_arready = (state == S_IDLE);
        assign s_rvalid  = crit_vld_q || (state == S_CMP && any_hit);
        assign s_rdata   = crit_vld_q ? crit_q : (hit0 ? way0.data : way1.data);

        assign m_araddr  = req_q.raw;
        assign m_arlen   = `ICACHE_ARLEN_W'(`ICACHE_WORDS - 1 - req_q.f.word);
        assign m_arvalid = (state == S_MREQ);
        assign m_rready  = (state == S_CRIT) || (state == S_REST);

        assign lookup  = (state == S_TAG);
        assign index   = req_q.f.index;
        assign word    = req_q.f.word;
        assign req_tag = req_q.f.tag;

        assign hit_clear0 = (state == S_CMP) && hit0 && s_rready;
        assign hit_clear1 = (state == S_CMP) && hit1 && s_rready;

        // Victim counts as used once its refill is committed
        assign used     = ((state == S_CMP) && any_hit && s_rready) ||
                          ((state == S_MREQ) && m_arready);
        assign used_way = (state == S_MREQ) ? victim_q : !hit0;

        always_comb
        begin
                refill.way_sel = victim_q ? 2'b10 : 2'b01;
                refill.index   = req_q.f.index;
                refill.tag     = req_q.f.tag;
                refill.word    = beat_q;
                refill.data    = m_rdata;
                refill.tag_we  = (state == S_MREQ) && m_arready;
                refill.data_we = beat;
        end

        assert property (@(posedge clk) disable iff (!resetn) $onehot(state));

        assert property (@(posedge clk) disable iff (!resetn)
                m_rvalid |-> (state == S_CRIT || state == S_REST));

        assert property (@(posedge clk) disable iff (!resetn)
                s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

/* icache_lru.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_lru import icache_pkg::*;
(
        input  logic                       clk,
        input  logic                       resetn,
        input  logic                       lookup,
        input  logic [`ICACHE_INDEX_W-1:0] index,
        input  logic                       used,
        input  logic                       used_way,
        input  way_lookup_t                way0,
        input  way_lookup_t                way1,
        output logic                       victim
);

        // One-hot record of the last used way or zero when never used
        logic [1:0] rec_mem [`ICACHE_SETS];
        logic [1:0] rec_q;

        always_ff @(posedge clk)
        begin
                if (!resetn)
                begin
                        for (int i = 0; i < `ICACHE_SETS; i++)
                        begin
                                rec_mem[i] <= 2'b00;
                        end
                end
                else if (used)
                        rec_mem[index] <= used_way ? 2'b10 : 2'b01;
        end

        always_ff @(posedge clk)
        begin
                if (!resetn)
                        rec_q <= 2'b00;
                else if (lookup)
                        rec_q <= rec_mem[index];
        end

        // Partial line of the same tag is refilled in place
        always_comb
        begin
                if (way0.hit && !way0.valid)
                        victim = 1'b0;
                else if (way1.hit && !way1.valid)
                        victim = 1'b1;
                else if (rec_q == 2'b00)
                        victim = 1'b0;
                else
                        victim = rec_q[0];
        end

        assert property (@(posedge clk) disable iff (!resetn) rec_q != 2'b11);

endmodule

/* icache_way.sv */
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_way import icache_pkg::*;
(
        input  logic                       clk,
        input  logic                       resetn,
        input  logic                       lookup,
        input  logic [`ICACHE_INDEX_W-1:0] index,
        input  logic [`ICACHE_WORD_W-1:0]  word,
        input  refill_wr_t                 refill,
        input  logic                       wr_en,
        input  logic                       hit_clear,
        input  logic [`ICACHE_TAG_W-1:0]   req_tag,
        output way_lookup_t                result
);

        logic [`ICACHE_LINE_W-1:0] data_mem [`ICACHE_SETS];
        logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_SETS];
        logic [`ICACHE_WORDS-1:0]  word_vld [`ICACHE_SETS];

        logic [`ICACHE_TAG_W-1:0]  tag_q;
        logic [31:0]               data_q;
        logic                      vld_q;
        logic                      live_q;

        //////////////////////////////////////////////////
        // Storage writes
        //////////////////////////////////////////////////
        always_ff @(posedge clk)
        begin
                if (wr_en && refill.tag_we)
                        tag_mem[refill.index] <= refill.tag;
                if (wr_en && refill.data_we)
                        data_mem[refill.index][refill.word*32 +: 32] <= refill.data;
        end

        // New tag empties the line and each beat fills one word
        always_ff @(posedge clk)
        begin
                if (!resetn)
                begin
                        for (int i = 0; i < `ICACHE_SETS; i++)
                        begin
                                word_vld[i] <= '0;
                        end
                end
                else if (wr_en && refill.tag_we)
                        word_vld[refill.index] <= '0;
                else if (wr_en && refill.data_we)
                        word_vld[refill.index][refill.word] <= 1'b1;
        end

        //////////////////////////////////////////////////
        // Registered lookup
        //////////////////////////////////////////////////
        always_ff @(posedge clk)
        begin
                if (lookup)
                begin
                        tag_q  <= tag_mem[index];
                        data_q <= data_mem[index][word*32 +: 32];
                end
        end

        always_ff @(posedge clk)
        begin
                if (!resetn)
                begin
                        vld_q  <= 1'b0;
                        live_q <= 1'b0;
                end
                else if (lookup)
                begin
                        vld_q  <= word_vld[index][word];
                        live_q <= |word_vld[index];
                end
                else if (hit_clear)
                        vld_q <= 1'b0;
        end

        always_comb
        begin
                result.tag   = tag_q;
                result.data  = data_q;
                result.valid = vld_q;
                result.hit   = live_q && (tag_q == req_tag);
        end

        // Tag update and beat writes belong to different controller states
        assert property (@(posedge clk) disable iff (!resetn)
                !(refill.tag_we && refill.data_we));

endmodule

/* icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

        // Request address as raw word or as fields
        typedef union packed {
                logic [31:0] raw;
                struct packed {
                        logic [`ICACHE_TAG_W-1:0]   tag;
                        logic [`ICACHE_INDEX_W-1:0] index;
                        logic [`ICACHE_WORD_W-1:0]  word;
                        logic [`ICACHE_BYTE_W-1:0]  byte_sel;
                } f;
        } icache_addr_u;

        // One way's answer to a lookup
        typedef struct packed {
                logic [`ICACHE_TAG_W-1:0] tag;
                logic [31:0]              data;
                logic                     valid;
                logic                     hit;     // tag matches a live line
        } way_lookup_t;

        // Refill write shared by both ways
        typedef struct packed {
                logic [1:0]                 way_sel;
                logic [`ICACHE_INDEX_W-1:0] index;
                logic [`ICACHE_TAG_W-1:0]   tag;
                logic [`ICACHE_WORD_W-1:0]  word;
                logic [31:0]                data;
                logic                       tag_we;
                logic                       data_we;
        } refill_wr_t;

endpackage

/* icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////////////////////////
// Address split over 32 bits
//////////////////////////////////////////////////
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  5
`define ICACHE_WORD_W   2
`define ICACHE_BYTE_W   2

//////////////////////////////////////////////////
// Geometry of 512 bytes per way
//////////////////////////////////////////////////
`define ICACHE_SETS     32
`define ICACHE_WORDS    4
`define ICACHE_LINE_W   128

// Burst length field holds beats minus one
`define ICACHE_ARLEN_W  8

`endif
